// File: pci_macros.svh
`ifndef PCI_MACROS_SVH
`define PCI_MACROS_SVH

////////////////////////////////////////
// Bus widths
////////////////////////////////////////
`define PCI_DATA_W       32            // AD bus, 32-bit only
`define PCI_BE_W         4             // C/BE# nibble

////////////////////////////////////////
// Memory window
////////////////////////////////////////
`define PCI_MEM_BASE     32'h0000_1000 // Byte address of word 0
`define PCI_MEM_WORDS    64            // Depth in 32-bit words
`define PCI_IDX_W        6             // log2 of the depth
`define PCI_ADDR_STEP    4             // Bytes per data phase

////////////////////////////////////////
// Read budgets in words
////////////////////////////////////////
`define PCI_READ_BUDGET  2             // Memory read
`define PCI_LINE_BUDGET  4             // Memory read line

`endif

// File: pci_pkg.sv
`include "pci_macros.svh"

package pci_pkg;

  ////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////
  typedef logic [`PCI_DATA_W-1:0] data_t;     // One AD word
  typedef logic [`PCI_BE_W-1:0]   be_t;       // Command or active-low byte enables
  typedef logic [`PCI_IDX_W-1:0]  word_idx_t; // Word index into the window
  typedef logic [$clog2(`PCI_LINE_BUDGET+1)-1:0] budget_t; // Words left in a read

  ////////////////////////////////////////
  // Bus commands served by the target
  ////////////////////////////////////////
  typedef enum logic [`PCI_BE_W-1:0] {
    mem_r      = 4'b0110,   // Memory read, short burst
    mem_w      = 4'b0111,   // Memory write
    mem_r_mult = 4'b1100,   // Memory read multiple, open ended
    mem_r_line = 4'b1110    // Memory read line
  } pci_cmd_t;

  // Target FSM states
  typedef enum logic [2:0] {
    idle,         // Bus free, waiting on frame
    decode,       // Address and command just captured
    wr_data,      // Write data phases
    turn_around,  // AD ownership change before read data
    rd_data,      // Read data phases
    disconnect,   // Stop held until frame goes high
    terminate     // One cycle with all strobes released
  } tgt_state_t;

endpackage

// File: pci_burst_addr.sv
`timescale 1ns/1ns
`include "pci_macros.svh"

module pci_burst_addr (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 addr_load,   // Address phase edge
  input  logic                 xfer,        // Data phase completes
  input  pci_pkg::data_t       ad_in,
  input  pci_pkg::be_t         c_be,
  output logic                 hit,         // Address inside the window
  output logic                 reserved,    // Low address bits not 00
  output pci_pkg::pci_cmd_t    cmd,
  output pci_pkg::word_idx_t   word_idx,
  output logic                 last_word,   // Current word is the window's top
  output logic                 budget_out   // Current word ends the read budget
);

  pci_pkg::data_t     byte_off;       // Offset from the window base
  logic               in_window;
  pci_pkg::word_idx_t idx_load;
  pci_pkg::pci_cmd_t  cmd_in;
  pci_pkg::budget_t   budget_load;
  pci_pkg::budget_t   budget;         // Zero means no limit

  ////////////////////////////////////////
  // Address phase decode
  ////////////////////////////////////////
  assign byte_off  = ad_in - `PCI_MEM_BASE;                          // Wraps high below base
  assign in_window = byte_off < (`PCI_MEM_WORDS * `PCI_ADDR_STEP);
  assign idx_load  = byte_off[`PCI_IDX_W+1:2];                       // Drop byte lane bits
  assign cmd_in    = pci_pkg::pci_cmd_t'(c_be);

  always_comb
  begin
    case (cmd_in)
      pci_pkg::mem_r      : budget_load = pci_pkg::budget_t'(`PCI_READ_BUDGET);
      pci_pkg::mem_r_line : budget_load = pci_pkg::budget_t'(`PCI_LINE_BUDGET);
      default             : budget_load = '0;                        // Write and read multiple
    endcase
  end

  ////////////////////////////////////////
  // Index stepping and budget count
  ////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      hit        <= 1'b0;
      reserved   <= 1'b0;
      last_word  <= 1'b0;
      budget_out <= 1'b0;
      budget     <= '0;
    end
    else if (addr_load)
    begin
      hit        <= in_window;
      reserved   <= ad_in[1:0] != 2'b00;                            // Only linear mode served
      last_word  <= idx_load == pci_pkg::word_idx_t'(`PCI_MEM_WORDS - 1);
      budget_out <= budget_load == pci_pkg::budget_t'(1);
      budget     <= budget_load;
    end
    else if (xfer)
    begin
      last_word  <= word_idx == pci_pkg::word_idx_t'(`PCI_MEM_WORDS - 2); // Next one is top
      budget_out <= budget == pci_pkg::budget_t'(2);                // One word left after this
      if (budget != '0)
        budget <= budget - 1'b1;
    end
  end

  // Word index steps through the burst, command held for the FSM
  always_ff @(posedge clk)
  begin
    if (addr_load)
    begin
      word_idx <= idx_load;
      cmd      <= cmd_in;
    end
    else if (xfer)
      word_idx <= word_idx + 1'b1;                                  // Linear increment
  end

endmodule

// File: pci_target_mem.sv
`timescale 1ns/1ns
`include "pci_macros.svh"

module pci_target_mem (
  input  logic               clk,
  input  logic               we,       // Write strobe from the FSM
  input  pci_pkg::word_idx_t idx,      // Shared read and write index
  input  pci_pkg::be_t       be,       // Byte enables, active low
  input  pci_pkg::data_t     wdata,
  output pci_pkg::data_t     rdata
);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////
  pci_pkg::data_t mem_q [`PCI_MEM_WORDS];   // Window contents

  // Byte lane writes
  always_ff @(posedge clk)
  begin
    if (we)
    begin
      for (int b = 0; b < `PCI_BE_W; b++)
      begin
        if (!be[b])                                       // Lane enabled when low
          mem_q[idx][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
  end

  ////////////////////////////////////////
  // Read port
  ////////////////////////////////////////

  // No clock on the read side, so the word at the
  // current index is on ad_out in the same cycle
  // the index changes
  assign rdata = mem_q[idx];

endmodule

// File: pci_target_fsm.sv
`timescale 1ns/1ns

module pci_target_fsm (
  input  logic              clk,
  input  logic              rst,
  input  logic              frame,       // Active low
  input  logic              irdy,        // Active low
  input  logic              hit,
  input  logic              reserved,
  input  logic              last_word,
  input  logic              budget_out,
  input  pci_pkg::pci_cmd_t cmd,
  output logic              addr_load,   // Capture address and command
  output logic              xfer,        // Data phase completes this edge
  output logic              mem_we,      // Memory write strobe
  output logic              devsel,      // Active low
  output logic              trdy,        // Active low
  output logic              stop,        // Active low
  output logic              ad_oe        // Target drives AD
);

  pci_pkg::tgt_state_t state;
  logic                cmd_known;       // One of the four served commands
  logic                cmd_write;
  logic                end_burst;       // Last word or budget reached

  ////////////////////////////////////////
  // Command classification
  ////////////////////////////////////////
  always_comb
  begin
    case (cmd)
      pci_pkg::mem_w :
      begin
        cmd_known = 1'b1;
        cmd_write = 1'b1;
      end
      pci_pkg::mem_r, pci_pkg::mem_r_line, pci_pkg::mem_r_mult :
      begin
        cmd_known = 1'b1;
        cmd_write = 1'b0;
      end
      default :
      begin
        cmd_known = 1'b0;                // Not claimed
        cmd_write = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////
  // Strobes toward burst unit and memory
  ////////////////////////////////////////
  assign addr_load = (state == pci_pkg::idle) && !frame;        // Address phase edge
  assign xfer      = !irdy && !trdy;                             // Both ready
  assign mem_we    = xfer && (state == pci_pkg::wr_data);
  assign end_burst = last_word || budget_out;

  ////////////////////////////////////////
  // State and PCI control outputs
  ////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      state  <= pci_pkg::idle;
      devsel <= 1'b1;                    // Released
      trdy   <= 1'b1;
      stop   <= 1'b1;
      ad_oe  <= 1'b0;                    // AD is input
    end
    else
    begin
      case (state)
        pci_pkg::idle :
        begin
          if (addr_load)
            state <= pci_pkg::decode;
        end

        pci_pkg::decode :
        begin
          if (hit && cmd_known)
          begin
            devsel <= 1'b0;              // Claim the cycle
            if (reserved)
            begin
              stop  <= 1'b0;             // Reject with no data
              state <= pci_pkg::disconnect;
            end
            else if (cmd_write)
            begin
              trdy  <= 1'b0;             // Ready for first write word
              state <= pci_pkg::wr_data;
            end
            else
              state <= pci_pkg::turn_around;
          end
          else if (frame)
            state <= pci_pkg::idle;      // Master gave up on the miss
        end

        pci_pkg::turn_around :
        begin
          trdy  <= 1'b0;
          ad_oe <= 1'b1;                 // Master has released AD
          state <= pci_pkg::rd_data;
        end

        pci_pkg::wr_data, pci_pkg::rd_data :
        begin
          if (xfer)
          begin
            if (frame)
            begin
              devsel <= 1'b1;            // Final phase done
              trdy   <= 1'b1;
              ad_oe  <= 1'b0;
              state  <= pci_pkg::terminate;
            end
            else if (end_burst)
            begin
              trdy  <= 1'b1;             // No more data this burst
              stop  <= 1'b0;
              ad_oe <= 1'b0;
              state <= pci_pkg::disconnect;
            end
          end
        end

        pci_pkg::disconnect :
        begin
          if (frame)
          begin
            devsel <= 1'b1;
            stop   <= 1'b1;
            state  <= pci_pkg::terminate;
          end
        end

        pci_pkg::terminate :
        begin
          state <= pci_pkg::idle;        // Bus back to idle
        end

        default :
        begin
          devsel <= 1'b1;
          trdy   <= 1'b1;
          stop   <= 1'b1;
          ad_oe  <= 1'b0;
          state  <= pci_pkg::idle;
        end
      endcase
    end
  end

endmodule

// File: pci_target_top.sv
`timescale 1ns/1ns

module pci_target_top (
  input  logic           clk,
  input  logic           rst,
  input  logic           frame,     // From master, active low
  input  logic           irdy,      // From master, active low
  input  pci_pkg::data_t ad_in,     // AD as seen from the bus
  input  pci_pkg::be_t   c_be,      // Command or byte enables
  output pci_pkg::data_t ad_out,    // Read data toward AD
  output logic           ad_oe,     // AD driver enable
  output logic           devsel,
  output logic           trdy,
  output logic           stop
);

  logic               addr_load;
  logic               xfer;
  logic               mem_we;
  logic               hit;
  logic               reserved;
  logic               last_word;
  logic               budget_out;
  pci_pkg::pci_cmd_t  cmd;
  pci_pkg::word_idx_t word_idx;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////
  pci_target_fsm i_pci_target_fsm (
    .clk        (clk),
    .rst        (rst),
    .frame      (frame),
    .irdy       (irdy),
    .hit        (hit),
    .reserved   (reserved),
    .last_word  (last_word),
    .budget_out (budget_out),
    .cmd        (cmd),
    .addr_load  (addr_load),
    .xfer       (xfer),
    .mem_we     (mem_we),
    .devsel     (devsel),
    .trdy       (trdy),
    .stop       (stop),
    .ad_oe      (ad_oe)
  );

  pci_burst_addr i_pci_burst_addr (
    .clk        (clk),
    .rst        (rst),
    .addr_load  (addr_load),
    .xfer       (xfer),
    .ad_in      (ad_in),
    .c_be       (c_be),
    .hit        (hit),
    .reserved   (reserved),
    .cmd        (cmd),
    .word_idx   (word_idx),
    .last_word  (last_word),
    .budget_out (budget_out)
  );

  ////////////////////////////////////////
  // Window storage
  ////////////////////////////////////////
  pci_target_mem i_pci_target_mem (
    .clk   (clk),
    .we    (mem_we),
    .idx   (word_idx),
    .be    (c_be),              // Byte enables in data phases
    .wdata (ad_in),
    .rdata (ad_out)             // Straight onto AD when enabled
  );

endmodule

// File: tb_pci_target.sv
`timescale 1ns/1ns
`include "pci_macros.svh"

module tb_pci_target;

  typedef struct packed {
    pci_pkg::be_t   cmd;
    pci_pkg::data_t addr;
    int             words;     // Words the master asks for
    pci_pkg::be_t   be;        // Active-low write byte enables
    int             kind;      // Expected outcome
    int             n_exp;     // Words expected to move
  } entry_t;

  localparam int res_done     = 0;   // Master ended the burst
  localparam int res_disc     = 1;   // Target stop
  localparam int res_abort    = 2;   // Master abort on no devsel
  localparam int reset_cycles = 10;
  localparam int devsel_wait  = 5;

  logic           clk, rst, frame, irdy, ad_oe, devsel, trdy, stop;
  pci_pkg::data_t ad_in, ad_out;
  pci_pkg::be_t   c_be;
  entry_t         table_q [$];
  pci_pkg::data_t ref_mem [`PCI_MEM_WORDS];  // Expected window contents
  logic [31:0]    lfsr_q;
  int             cycle_cnt, cycle_limit;

  pci_target_top i_pci_target_top (.clk(clk), .rst(rst), .frame(frame), .irdy(irdy),
    .ad_in(ad_in), .c_be(c_be), .ad_out(ad_out), .ad_oe(ad_oe), .devsel(devsel),
    .trdy(trdy), .stop(stop));

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;                  // 100 ns period
  end

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit)
    begin
      $display("Timeout: run went past %0d clock cycles without finishing", cycle_limit);
      $display("*** TEST FAILED ***");
      $fatal(1, "Simulation hung");
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  function automatic logic take_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]; // Taps 32 22 2 1
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic pci_pkg::data_t random_word();
    pci_pkg::data_t w;
    w = '0;
    for (int i = 0; i < 32; i++)
      w = {w[30:0], take_bit()};             // One step per bit
    return w;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #10;                                     // Drive and sample point
  endtask

  task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
    if (actual !== expected)
    begin
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "Check failed");
    end
  endtask

  task automatic merge_ref(input pci_pkg::word_idx_t idx, input pci_pkg::data_t data,
                           input pci_pkg::be_t be);
    for (int b = 0; b < `PCI_BE_W; b++)
      if (!be[b])
        ref_mem[idx][8*b +: 8] = data[8*b +: 8];   // Lane written when enable is 0
  endtask

  task automatic add_entry(input pci_pkg::be_t cmd, input pci_pkg::data_t addr,
                           input int words, input pci_pkg::be_t be, input int kind,
                           input int n_exp);
    entry_t e;
    e.cmd   = cmd;
    e.addr  = addr;
    e.words = words;
    e.be    = be;
    e.kind  = kind;
    e.n_exp = n_exp;
    table_q.push_back(e);
  endtask

  // One data phase with a wait state on about one phase in four
  task automatic drive_phase(input int remaining, input pci_pkg::data_t data,
                             input pci_pkg::be_t be, input bit write);
    c_be  = be;
    ad_in = write ? data : '0;               // Master leaves AD in reads
    if (take_bit() & take_bit())
    begin
      irdy  = 1'b1;
      frame = 1'b0;
    end
    else
    begin
      irdy  = 1'b0;
      frame = (remaining == 1);              // Last phase
    end
  endtask

  ////////////////////////////////////////
  // Master model for one table entry
  ////////////////////////////////////////
  task automatic apply_entry(input int num, input entry_t e);
    int                 count;
    int                 no_devsel;
    int                 outcome;
    bit                 done;
    bit                 is_write;
    pci_pkg::word_idx_t start_idx;
    pci_pkg::word_idx_t cur_idx;
    pci_pkg::data_t     wdata;
    count     = 0;
    no_devsel = 0;
    outcome   = res_done;
    done      = 1'b0;
    is_write  = (e.cmd == pci_pkg::mem_w);
    start_idx = pci_pkg::word_idx_t'((e.addr - `PCI_MEM_BASE) >> 2);
    frame = 1'b0;                            // Address phase
    irdy  = 1'b1;
    ad_in = e.addr;
    c_be  = e.cmd;
    next_cycle();
    wdata = random_word();
    drive_phase(e.words, wdata, e.be, is_write);
    while (!done)
    begin
      if (!stop)
      begin
        compare_value(32'(trdy), 1, $sformatf("entry %0d trdy high with stop", num));
        compare_value(32'(devsel), 0, $sformatf("entry %0d devsel low with stop", num));
        outcome = res_disc;
        frame   = 1'b1;                      // Finish the phase with no data
        irdy    = 1'b0;
        next_cycle();
        done    = 1'b1;
      end
      else if (!irdy && !trdy)
      begin
        cur_idx = start_idx + pci_pkg::word_idx_t'(count);
        compare_value(32'(devsel), 0, $sformatf("entry %0d devsel in transfer", num));
        compare_value(32'(ad_oe), 32'(!is_write), $sformatf("entry %0d ad_oe", num));
        if (is_write)
          merge_ref(cur_idx, wdata, e.be);
        else
          compare_value(ad_out, ref_mem[cur_idx],
                        $sformatf("entry %0d read data at word %0d", num, cur_idx));
        count++;
        next_cycle();
        if (frame)
          done = 1'b1;                       // Final phase just completed
        else
        begin
          wdata = random_word();
          drive_phase(e.words - count, wdata, e.be, is_write);
        end
      end
      else if (devsel && no_devsel >= devsel_wait)
      begin
        outcome = res_abort;                 // Nobody claimed the cycle
        frame   = 1'b1;
        irdy    = 1'b0;
        next_cycle();
        done    = 1'b1;
      end
      else
      begin
        if (devsel)
          no_devsel++;
        next_cycle();
        if (irdy)
        begin
          irdy  = 1'b0;                      // Wait state over
          frame = ((e.words - count) == 1);
        end
      end
    end
    irdy  = 1'b1;
    frame = 1'b1;
    ad_in = '0;
    c_be  = '0;
    compare_value({devsel, trdy, stop, ad_oe}, 4'b1110,
                  $sformatf("entry %0d strobes released after burst", num));
    next_cycle();
    compare_value(outcome, e.kind, $sformatf("entry %0d outcome", num));
    compare_value(count, e.n_exp, $sformatf("entry %0d words moved", num));
  endtask

  ////////////////////////////////////////
  // Transaction table and main sequence
  ////////////////////////////////////////
  initial
  begin
    frame = 1'b1;
    irdy  = 1'b1;
    ad_in = '0;
    c_be  = '0;
    rst   = 1'b0;
    lfsr_q      = 32'h6fbd;
    cycle_cnt   = 0;
    cycle_limit = 0;
    add_entry(pci_pkg::mem_w,      `PCI_MEM_BASE,          6, 4'b0000, res_done,  6);
    add_entry(pci_pkg::mem_r_mult, `PCI_MEM_BASE,          6, 4'b0000, res_done,  6);
    add_entry(pci_pkg::mem_w,      `PCI_MEM_BASE + 32'd8,  2, 4'b1010, res_done,  2);
    add_entry(pci_pkg::mem_r_mult, `PCI_MEM_BASE,          4, 4'b0000, res_done,  4);
    add_entry(pci_pkg::mem_r,      `PCI_MEM_BASE,          4, 4'b0000, res_disc,  2);
    add_entry(pci_pkg::mem_w,      `PCI_MEM_BASE + 32'd64, 6, 4'b0000, res_done,  6);
    add_entry(pci_pkg::mem_r_line, `PCI_MEM_BASE + 32'd64, 6, 4'b0000, res_disc,  4);
    add_entry(pci_pkg::mem_w,      `PCI_MEM_BASE + 32'd248, 4, 4'b0000, res_disc, 2); // Top
    add_entry(pci_pkg::mem_r_mult, `PCI_MEM_BASE + 32'd248, 2, 4'b0000, res_done, 2);
    add_entry(pci_pkg::mem_r_mult, `PCI_MEM_BASE,          6, 4'b0000, res_done,  6); // No wrap
    add_entry(pci_pkg::mem_w,      32'h0000_2000,          3, 4'b0000, res_abort, 0);
    add_entry(pci_pkg::mem_r,      32'h0000_0ff0,          3, 4'b0000, res_abort, 0);
    add_entry(pci_pkg::mem_r_mult, `PCI_MEM_BASE + 32'd1,  2, 4'b0000, res_disc,  0);
    add_entry(pci_pkg::mem_r_mult, `PCI_MEM_BASE + 32'd64, 2, 4'b0000, res_done,  2);
    cycle_limit = reset_cycles;
    foreach (table_q[i])
      cycle_limit += 3 * table_q[i].words + 12;
    repeat (reset_cycles) @(posedge clk);
    #10;
    rst = 1'b1;
    compare_value({devsel, trdy, stop, ad_oe}, 4'b1110, "strobes after reset");
    foreach (table_q[i])
      apply_entry(i, table_q[i]);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: all.f
+incdir+.
pci_pkg.sv
pci_burst_addr.sv
pci_target_mem.sv
pci_target_fsm.sv
pci_target_top.sv
tb_pci_target.sv

// File: run.sh
#!/bin/sh
# Build and run the PCI target simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_pci_target -o sim_pci_target

out=$(./obj_dir/sim_pci_target 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1
